/* verilog/scurvePkg.sv */
package scurvePkg;

  ////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////
  typedef logic [9:0]   dacCode_t;     // Threshold DAC code
  typedef logic [5:0]   chan_t;        // Channel number inside one ASIC
  typedef logic [2:0]   asicCount_t;   // ASIC count or index in the chain
  typedef logic [15:0]  dataWord_t;    // Output stream word
  typedef logic [63:0]  ctestMask_t;   // One-hot charge injection enable
  typedef logic [191:0] discriMask_t;  // Three discriminator bits per channel

  // Run parameters, held stable by the host during a run
  typedef struct packed {
    logic       singleChannel;  // High for single channel, low for 64-channel scan
    chan_t      testChannel;
    logic       ctestInject;    // Inject through Ctest pin
    dacCode_t   startDac;
    dacCode_t   endDac;
    dacCode_t   dacStep;
    asicCount_t asicCount;
    asicCount_t testAsic;
    logic       unmaskAll;
  } scurveCfg_t;

  // Slow-control frame, shifted MSB first
  typedef struct packed {
    ctestMask_t  ctest;
    dacCode_t    dac;
    discriMask_t mask;
  } scFrame_t;

  ////////////////////////////////////////
  // Stream word codes
  ////////////////////////////////////////
  localparam dataWord_t  HEADER_WORD     = 16'h5343;  // "SC"
  localparam dataWord_t  TAIL_WORD       = 16'hFF45;
  localparam logic [7:0] CHAN_TAG_SINGLE = 8'h43;     // "C"
  localparam logic [7:0] CHAN_TAG_SCAN   = 8'h63;     // "c"
  localparam dataWord_t  UNMASK_WORD     = 16'h43FF;
  localparam logic [3:0] DAC_TAG         = 4'hD;

  // Timing and sizing
  localparam int SC_FRAME_BITS = 266;
  localparam int SETTLE_CYCLES = 8;
  localparam int INJECT_PULSES = 16;
  localparam int INJECT_PERIOD = 4;
  localparam int TAIL_GAP      = 15;
  localparam int FIFO_DEPTH    = 8;
  localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

endpackage

/* verilog/triggerCounter.sv */
`timescale 1ns/10ps

module triggerCounter (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 pointStart,
  output logic                 pointDone,
  output logic                 injectPulse,
  input  logic                 trigger,
  output scurvePkg::dataWord_t countWord,
  output logic                 countValid,
  input  logic                 countReady
);
  import scurvePkg::*;

  typedef enum logic [1:0] {IDLE, INJECT, PUSH} state_t;

  state_t                           state;
  logic [$clog2(INJECT_PERIOD)-1:0] phase;     // Cycle inside one injection
  logic [$clog2(INJECT_PULSES)-1:0] pulseNum;
  logic                             hitSeen;
  logic                             hit;
  dataWord_t                        hitCount;

  // Injection occupies the first half of each period
  assign injectPulse = (state == INJECT) && (phase < INJECT_PERIOD / 2);
  assign hit         = hitSeen | (trigger & injectPulse);
  assign countWord   = hitCount;
  assign countValid  = (state == PUSH);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= IDLE;
      phase     <= '0;
      pulseNum  <= '0;
      hitSeen   <= 1'b0;
      hitCount  <= '0;
      pointDone <= 1'b0;
    end else begin
      pointDone <= 1'b0;
      case (state)
        IDLE: begin
          if (pointStart) begin
            phase    <= '0;
            pulseNum <= '0;
            hitSeen  <= 1'b0;
            hitCount <= '0;
            state    <= INJECT;
          end
        end
        INJECT: begin
          if (phase == INJECT_PERIOD - 1) begin
            // Close this injection and score it once
            phase    <= '0;
            hitSeen  <= 1'b0;
            hitCount <= hitCount + dataWord_t'(hit);
            pulseNum <= pulseNum + 1'b1;
            if (pulseNum == INJECT_PULSES - 1)
              state <= PUSH;
          end else begin
            phase   <= phase + 1'b1;
            hitSeen <= hit;
          end
        end
        PUSH: begin
          if (countReady) begin  // Held until the FIFO takes it
            pointDone <= 1'b1;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // The controller waits for pointDone before it starts the next point
  assert property (@(posedge Clk) disable iff (!reset_n) pointStart |-> state == IDLE);

endmodule

/* verilog/dataFifo.sv */
`timescale 1ns/10ps

module dataFifo (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  scurvePkg::dataWord_t inWord,
  input  logic                 inValid,
  output logic                 inReady,
  output scurvePkg::dataWord_t outWord,
  output logic                 outValid,
  input  logic                 outReady
);
  import scurvePkg::*;

  dataWord_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_BITS:0] wrPtr;  // Extra MSB tells full from empty
  logic [FIFO_PTR_BITS:0] rdPtr;
  logic [FIFO_PTR_BITS:0] fill;
  logic                   push;
  logic                   pop;

  assign fill     = wrPtr - rdPtr;
  assign inReady  = (fill != FIFO_DEPTH);
  assign outValid = (fill != 0);
  assign push     = inValid & inReady;
  assign pop      = outValid & outReady;
  assign outWord  = mem[rdPtr[FIFO_PTR_BITS-1:0]];

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  always_ff @(posedge Clk) begin
    if (push)
      mem[wrPtr[FIFO_PTR_BITS-1:0]] <= inWord;
  end

  ////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  // A word refused while full is held by the producer, never lost
  assert property (@(posedge Clk) disable iff (!reset_n)
    inValid && !inReady |=> inValid && $stable(inWord));

endmodule

/* verilog/configLoader.sv */
`timescale 1ns/10ps

module configLoader (
  input  logic                Clk,
  input  logic                reset_n,
  input  logic                loadStart,
  input  scurvePkg::scFrame_t frame,
  output logic                loadDone,
  output logic                scClk,
  output logic                scData,
  output logic                scSelect
);
  import scurvePkg::*;

  typedef enum logic [1:0] {IDLE, SHIFT, SETTLE} state_t;

  state_t                           state;
  logic                             phase;     // High in second half of scClk
  logic [$clog2(SC_FRAME_BITS)-1:0] bitCnt;
  logic [$clog2(SETTLE_CYCLES)-1:0] settleCnt;
  logic [SC_FRAME_BITS-1:0]         shiftReg;

  assign scSelect = (state == SHIFT);
  assign scClk    = scSelect & phase;
  assign scData   = scSelect & shiftReg[SC_FRAME_BITS-1];  // MSB first
  assign loadDone = (state == SETTLE) && (settleCnt == SETTLE_CYCLES - 1);

  always_ff @(posedge Clk) begin
    if (state == IDLE && loadStart)
      shiftReg <= frame;
    else if (scSelect && phase)
      shiftReg <= shiftReg << 1;  // Next bit after the ASIC sampled this one
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= IDLE;
      phase     <= 1'b0;
      bitCnt    <= '0;
      settleCnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (loadStart) begin
            phase  <= 1'b0;
            bitCnt <= '0;
            state  <= SHIFT;
          end
        end
        SHIFT: begin
          phase <= ~phase;
          if (phase) begin
            if (bitCnt == SC_FRAME_BITS - 1) begin
              settleCnt <= '0;
              state     <= SETTLE;
            end else begin
              bitCnt <= bitCnt + 1'b1;
            end
          end
        end
        SETTLE: begin
          if (loadDone)
            state <= IDLE;
          else
            settleCnt <= settleCnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // The controller sends one frame at a time
  assert property (@(posedge Clk) disable iff (!reset_n) loadStart |-> state == IDLE);

endmodule

/* verilog/scurveTestControl.sv */
`timescale 1ns/10ps

module scurveTestControl (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  scurvePkg::scurveCfg_t cfg,
  output logic                  pointStart,
  input  logic                  pointDone,
  input  scurvePkg::dataWord_t  fifoWord,
  input  logic                  fifoValid,
  output logic                  fifoReady,
  output logic                  loadStart,
  output scurvePkg::scFrame_t   frame,
  input  logic                  loadDone,
  output scurvePkg::dacCode_t   dacCode,
  output scurvePkg::dataWord_t  outWord,
  output logic                  outValid,
  input  logic                  outReady,
  output logic                  runDone,
  input  logic                  transmitDone
);
  import scurvePkg::*;

  typedef enum logic [3:0] {
    IDLE, HEADER, CHANNEL, DAC_OUT, SELECT_MASK, LOAD, LOAD_WAIT, POINT_RUN,
    POINT_WAIT, DRAIN, NEXT_DAC, NEXT_CHAN, TAIL_WAIT, DONE, SEND
  } state_t;

  state_t                      state;
  state_t                      afterSend;  // Where to go once the word is taken
  dacCode_t                    dacReg;
  chan_t                       chanReg;
  chan_t                       chan;
  asicCount_t                  asicIdx;
  asicCount_t                  targetAsic;
  discriMask_t                 chanMask;
  logic [$clog2(TAIL_GAP)-1:0] tailCnt;

  // The ASIC frame expects the DAC LSB first
  function automatic dacCode_t reverseBits(input dacCode_t code);
    dacCode_t rev;
    for (int i = 0; i < $bits(dacCode_t); i++) begin
      rev[i] = code[$bits(dacCode_t) - 1 - i];
    end
    return rev;
  endfunction

  assign chan       = cfg.singleChannel ? cfg.testChannel : chanReg;
  assign targetAsic = cfg.asicCount - cfg.testAsic - 3'd1;  // Chain loads far end first
  assign dacCode    = dacReg;
  assign fifoReady  = (state == DRAIN);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= IDLE;
      afterSend  <= IDLE;
      dacReg     <= '0;
      chanReg    <= '0;
      asicIdx    <= '0;
      chanMask   <= '0;
      tailCnt    <= '0;
      frame      <= '0;
      outWord    <= '0;
      outValid   <= 1'b0;
      pointStart <= 1'b0;
      loadStart  <= 1'b0;
      runDone    <= 1'b0;
    end else begin
      pointStart <= 1'b0;
      loadStart  <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            dacReg  <= cfg.startDac;
            chanReg <= '0;
            state   <= HEADER;
          end
        end
        HEADER: begin
          outWord   <= HEADER_WORD;
          outValid  <= 1'b1;
          afterSend <= CHANNEL;
          state     <= SEND;
        end
        ////////////////////////////////////////
        // Per channel setup
        ////////////////////////////////////////
        CHANNEL: begin
          if (cfg.unmaskAll) begin
            outWord  <= UNMASK_WORD;
            chanMask <= '1;
          end else begin
            outWord  <= {cfg.singleChannel ? CHAN_TAG_SINGLE : CHAN_TAG_SCAN, 2'b00, chan};
            chanMask <= discriMask_t'(3'b111) << (3 * chan);
          end
          frame.ctest <= cfg.ctestInject ? (ctestMask_t'(1) << chan) : '0;
          outValid    <= 1'b1;
          afterSend   <= DAC_OUT;
          state       <= SEND;
        end
        DAC_OUT: begin
          outWord   <= {DAC_TAG, 2'b00, dacReg};
          frame.dac <= reverseBits(dacReg);
          asicIdx   <= '0;
          outValid  <= 1'b1;
          afterSend <= SELECT_MASK;
          state     <= SEND;
        end
        SELECT_MASK: begin
          if (asicIdx == cfg.asicCount) begin
            state <= POINT_RUN;  // Whole chain loaded
          end else begin
            frame.mask <= (asicIdx == targetAsic) ? chanMask : '0;
            state      <= LOAD;
          end
        end
        LOAD: begin
          loadStart <= 1'b1;
          asicIdx   <= asicIdx + 1'b1;
          state     <= LOAD_WAIT;
        end
        LOAD_WAIT: begin
          if (loadDone)
            state <= SELECT_MASK;
        end
        ////////////////////////////////////////
        // Point run and readout
        ////////////////////////////////////////
        POINT_RUN: begin
          pointStart <= 1'b1;
          state      <= POINT_WAIT;
        end
        POINT_WAIT: begin
          if (pointDone)
            state <= DRAIN;
        end
        DRAIN: begin
          if (fifoValid) begin  // Popped on this edge
            outWord   <= fifoWord;
            outValid  <= 1'b1;
            afterSend <= DRAIN;
            state     <= SEND;
          end else begin
            state <= NEXT_DAC;
          end
        end
        NEXT_DAC: begin
          if (dacReg >= cfg.endDac) begin
            state <= NEXT_CHAN;
          end else begin
            dacReg <= dacReg + cfg.dacStep;
            state  <= DAC_OUT;
          end
        end
        NEXT_CHAN: begin
          if (cfg.singleChannel || chanReg == '1) begin
            outWord   <= TAIL_WORD;
            outValid  <= 1'b1;
            tailCnt   <= '0;
            afterSend <= TAIL_WAIT;
            state     <= SEND;
          end else begin
            chanReg <= chanReg + 1'b1;
            dacReg  <= cfg.startDac;
            state   <= CHANNEL;
          end
        end
        TAIL_WAIT: begin
          if (tailCnt == TAIL_GAP - 1) begin
            runDone <= 1'b1;
            state   <= DONE;
          end else begin
            tailCnt <= tailCnt + 1'b1;
          end
        end
        DONE: begin
          if (transmitDone) begin  // Host has read everything
            runDone <= 1'b0;
            state   <= IDLE;
          end
        end
        SEND: begin
          if (outReady) begin
            outValid <= 1'b0;
            state    <= afterSend;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Word and valid held under back-pressure
  assert property (@(posedge Clk) disable iff (!reset_n)
    outValid && !outReady |=> outValid && $stable(outWord));

endmodule

/* verilog/scurveTop.sv */
`timescale 1ns/10ps

module scurveTop (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  scurvePkg::scurveCfg_t cfg,
  output scurvePkg::dataWord_t  outWord,
  output logic                  outValid,
  input  logic                  outReady,
  output logic                  runDone,
  input  logic                  transmitDone,
  output scurvePkg::dacCode_t   dacCode,
  output logic                  scClk,
  output logic                  scData,
  output logic                  scSelect,
  output logic                  injectPulse,
  input  logic                  trigger
);
  import scurvePkg::*;

  logic      pointStart;
  logic      pointDone;
  dataWord_t countWord;
  logic      countValid;
  logic      countReady;
  dataWord_t fifoWord;
  logic      fifoValid;
  logic      fifoReady;
  logic      loadStart;
  logic      loadDone;
  scFrame_t  frame;

  // Producer
  triggerCounter counter (.Clk, .reset_n, .pointStart, .pointDone, .injectPulse, .trigger,
    .countWord, .countValid, .countReady);

  dataFifo fifo (.Clk, .reset_n, .inWord(countWord), .inValid(countValid),
    .inReady(countReady), .outWord(fifoWord), .outValid(fifoValid), .outReady(fifoReady));

  // Consumer and sequencer
  scurveTestControl control (.Clk, .reset_n, .start, .cfg, .pointStart, .pointDone,
    .fifoWord, .fifoValid, .fifoReady, .loadStart, .frame, .loadDone, .dacCode,
    .outWord, .outValid, .outReady, .runDone, .transmitDone);

  configLoader loader (.Clk, .reset_n, .loadStart, .frame, .loadDone, .scClk, .scData,
    .scSelect);

endmodule

/* verification/scurveTopTb.sv */
`timescale 1ns/10ps

module scurveTopTb;
  import scurvePkg::*;

  localparam int MODEL_THRESHOLD = 300;  // ASIC model fires below this DAC code
  localparam int POINTS          = 5;    // 280 to 320 in steps of 10
  localparam int DAC_FIRST_BIT   = $bits(ctestMask_t);  // DAC field follows ctest

  logic       Clk;
  logic       reset_n;
  logic       start;
  scurveCfg_t cfg;
  dataWord_t  outWord;
  logic       outValid;
  logic       outReady;
  logic       runDone;
  logic       transmitDone;
  dacCode_t   dacCode;
  logic       scClk;
  logic       scData;
  logic       scSelect;
  logic       injectPulse;
  logic       trigger;

  integer      seed = 32'hd3251242;
  logic [31:0] rnd;
  logic        randomReady;
  int          errors      = 0;
  int          testsRun    = 0;
  int          testsFailed = 0;
  logic        timedOut    = 1'b0;

  // Logs filled by the monitor
  dataWord_t wordLog[$];
  dataWord_t refLog[$];
  int        frameEdges[$];
  dacCode_t  frameDac[$];
  int        cyc        = 0;
  int        tailCyc    = 0;
  int        riseCyc    = 0;
  int        edgeCount  = 0;
  dacCode_t  dacBits    = '0;
  logic      scClkPrev  = 1'b0;
  logic      selectPrev = 1'b0;
  logic      runDonePrev = 1'b0;

  scurveTop DUT (.Clk, .reset_n, .start, .cfg, .outWord, .outValid, .outReady, .runDone,
    .transmitDone, .dacCode, .scClk, .scData, .scSelect, .injectPulse, .trigger);

  initial begin
    Clk = 1'b0;
    forever #20 Clk = ~Clk;
  end

  ////////////////////////////////////////
  // ASIC and host models
  ////////////////////////////////////////
  always @(posedge Clk) begin
    trigger <= injectPulse && (dacCode < MODEL_THRESHOLD);  // Discriminator one cycle late
  end

  always @(posedge Clk) begin
    rnd = $random(seed);
    outReady <= randomReady ? rnd[0] : 1'b1;
  end

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////
  always @(posedge Clk) begin
    cyc++;
    if (outValid && outReady) begin
      wordLog.push_back(outWord);
      if (outWord == TAIL_WORD)
        tailCyc = cyc;
    end
    if (runDone && !runDonePrev)
      riseCyc = cyc;
    // The frame carries the code LSB first, so DAC bit k shifted out is code bit k
    if (scClk && !scClkPrev) begin
      if (edgeCount >= DAC_FIRST_BIT && edgeCount < DAC_FIRST_BIT + $bits(dacCode_t))
        dacBits[edgeCount - DAC_FIRST_BIT] = scData;
      edgeCount++;
    end
    if (!scSelect && selectPrev) begin  // End of one frame
      frameEdges.push_back(edgeCount);
      frameDac.push_back(dacBits);
      edgeCount = 0;
    end
    scClkPrev   = scClk;
    selectPrev  = scSelect;
    runDonePrev = runDone;
  end

  // Stream and done handshake rules
  assert property (@(posedge Clk) disable iff (!reset_n)
    outValid && !outReady |=> outValid && $stable(outWord))
  else begin
    errors++;
    $display("CHECK FAILED at %0t: outWord changed or dropped while stalled", $time);
  end

  assert property (@(posedge Clk) disable iff (!reset_n) runDone && !transmitDone |=> runDone)
  else begin
    errors++;
    $display("CHECK FAILED at %0t: runDone fell before transmitDone", $time);
  end

  assert property (@(posedge Clk) disable iff (!reset_n) runDone && transmitDone |=> !runDone)
  else begin
    errors++;
    $display("CHECK FAILED at %0t: runDone stayed high after transmitDone", $time);
  end

  task automatic expectEqual(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    testsRun++;
    if (errors == errsBefore) begin
      $display("Test %0d %s: PASS", testsRun, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: FAIL", testsRun, name);
    end
  endtask

  // One full run, ended by the host with transmitDone
  task automatic runScan(input scurveCfg_t runCfg, input int limit);
    int n;
    wordLog.delete();
    frameEdges.delete();
    frameDac.delete();
    @(posedge Clk);
    cfg   <= runCfg;
    start <= 1'b1;
    @(posedge Clk);
    start <= 1'b0;
    n = 0;
    while (!runDone && n < limit) begin
      @(posedge Clk);
      n++;
    end
    if (!runDone) begin
      timedOut = 1'b1;
      $display("Timeout: runDone did not rise within %0d cycles", limit);
    end else begin
      repeat (4) @(posedge Clk);
      transmitDone <= 1'b1;
      @(posedge Clk);
      transmitDone <= 1'b0;
      n = 0;
      while (runDone && n < 10) begin
        @(posedge Clk);
        n++;
      end
      if (runDone) begin
        timedOut = 1'b1;
        $display("Timeout: runDone did not fall after transmitDone");
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    scurveCfg_t singleCfg;
    scurveCfg_t unmaskCfg;
    scurveCfg_t scanCfg;
    int         p;
    int         j;
    int         ch;
    int         errsBefore;
    dacCode_t   dac;

    reset_n      = 1'b0;
    start        = 1'b0;
    cfg          = '0;
    outReady     = 1'b0;
    transmitDone = 1'b0;
    trigger      = 1'b0;
    randomReady  = 1'b0;
    singleCfg = '{singleChannel: 1'b1, testChannel: 6'd5, ctestInject: 1'b1,
                  startDac: 10'd280, endDac: 10'd320, dacStep: 10'd10,
                  asicCount: 3'd3, testAsic: 3'd1, unmaskAll: 1'b0};
    unmaskCfg           = singleCfg;
    unmaskCfg.unmaskAll = 1'b1;
    unmaskCfg.startDac  = 10'd100;
    unmaskCfg.endDac    = 10'd100;
    unmaskCfg.asicCount = 3'd1;
    unmaskCfg.testAsic  = 3'd0;
    scanCfg               = unmaskCfg;
    scanCfg.unmaskAll     = 1'b0;
    scanCfg.singleChannel = 1'b0;

    repeat (3) @(posedge Clk);
    reset_n <= 1'b1;

    // Single channel with ready always high
    errsBefore = errors;
    runScan(singleCfg, 20000);
    if (!timedOut) begin
      expectEqual(wordLog.size(), 2 + 2 * POINTS + 1, "stream length");
      expectEqual(wordLog[0], 16'h5343, "header word");
      expectEqual(wordLog[1], 16'h4305, "channel word");
      for (p = 0; p < POINTS; p++) begin
        dac = dacCode_t'(280 + 10 * p);
        expectEqual(wordLog[2 + 2 * p], {DAC_TAG, 2'b00, dac}, $sformatf("DAC word %0d", p));
      end
      expectEqual(wordLog[wordLog.size() - 1], 16'hFF45, "tail word");
      refLog = wordLog;
      reportTest("single channel stream", errsBefore);

      errsBefore = errors;
      for (p = 0; p < POINTS; p++) begin
        dac = dacCode_t'(280 + 10 * p);
        expectEqual(wordLog[3 + 2 * p], (dac < MODEL_THRESHOLD) ? INJECT_PULSES : 0,
          $sformatf("count at DAC %0d", dac));
      end
      reportTest("s-curve counts", errsBefore);

      errsBefore = errors;
      expectEqual(frameEdges.size(), singleCfg.asicCount * POINTS, "frames loaded");
      for (j = 0; j < frameEdges.size(); j++) begin
        expectEqual(frameEdges[j], SC_FRAME_BITS, $sformatf("scClk edges in frame %0d", j));
        expectEqual(frameDac[j], dacCode_t'(280 + 10 * (j / 3)), $sformatf("DAC in frame %0d", j));
      end
      reportTest("slow-control frames", errsBefore);
    end

    // Same run under random back-pressure
    if (!timedOut) begin
      errsBefore = errors;
      randomReady <= 1'b1;
      runScan(singleCfg, 40000);
      randomReady <= 1'b0;
      expectEqual(wordLog.size(), refLog.size(), "stream length under back-pressure");
      for (j = 0; j < refLog.size(); j++)
        expectEqual(wordLog[j], refLog[j], $sformatf("word %0d under back-pressure", j));
      reportTest("back-pressure", errsBefore);
    end

    // Unmask-all, then a 64-channel scan, one DAC point each
    if (!timedOut) begin
      errsBefore = errors;
      runScan(unmaskCfg, 5000);
      expectEqual(wordLog.size(), 5, "unmask stream length");
      expectEqual(wordLog[1], 16'h43FF, "unmask channel word");
      if (!timedOut) begin
        runScan(scanCfg, 100000);
        expectEqual(wordLog.size(), 2 + 64 * 3, "scan stream length");
        for (ch = 0; ch < 64; ch++)
          expectEqual(wordLog[1 + 3 * ch], 16'h6300 + ch, $sformatf("scan channel %0d", ch));
      end
      reportTest("unmask and channel scan", errsBefore);
    end

    // Done handshake and restart
    if (!timedOut) begin
      errsBefore = errors;
      runScan(unmaskCfg, 5000);
      expectEqual(wordLog[0], 16'h5343, "header after restart");
      // runDone rises TAIL_GAP edges after the tail and is sampled high one edge later
      expectEqual(riseCyc - tailCyc, TAIL_GAP + 1, "tail to runDone delay");
      reportTest("done handshake", errsBefore);
    end

    $display("Tests run: %0d, failed: %0d, check errors: %0d", testsRun, testsFailed, errors);
    if (timedOut || errors != 0 || testsFailed != 0)
      $display("SOME TESTS FAILED");
    else
      $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* project.f */
verilog/scurvePkg.sv
verilog/triggerCounter.sv
verilog/dataFifo.sv
verilog/configLoader.sv
verilog/scurveTestControl.sv
verilog/scurveTop.sv
verification/scurveTopTb.sv

/* Makefile */
# Verilator simulation of the S-curve scan testbench
VERILATOR ?= verilator
TOP       ?= scurveTopTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
